//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= pix_subsystem_tb
FILELIST ?= pix_subsystem.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- pix_subsystem.f
src/pix_geometry_pkg.sv
src/pix_types_pkg.sv
src/pix_capture.sv
src/block_store.sv
src/pix_controller.sv
src/pix_subsystem.sv
verif/pix_subsystem_tb.sv

//--- src/block_store.sv
module block_store (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    store_cmd_trigger,
    input  logic [pix_geometry_pkg::BLOCK_BITS-1:0] store_cmd_block,
    input  logic                                    store_cmd_write,
    output logic                                    store_cmd_ready,
    input  logic                                    store_write_trigger,
    input  logic [pix_geometry_pkg::WORD_BITS-1:0]  store_write_data,
    output logic                                    store_write_ready,
    input  logic                                    store_read_trigger,
    output logic                                    store_read_ready,
    output logic [pix_geometry_pkg::WORD_BITS-1:0]  store_read_data
);

    // ==================================================================
    // Word array, addressed as {block, word}
    // ==================================================================
    logic [pix_geometry_pkg::WORD_BITS-1:0]
        mem [pix_geometry_pkg::BLOCK_COUNT * pix_geometry_pkg::IMAGE_WORDS];

    pix_types_pkg::store_state_e                state;
    logic [pix_geometry_pkg::BLOCK_BITS-1:0]     blk;
    logic [pix_geometry_pkg::WORD_ADDR_BITS-1:0] word_cnt;
    logic                                        write_xfer;
    logic                                        read_xfer;
    logic                                        last_word;

    assign store_cmd_ready   = (state == pix_types_pkg::ST_IDLE);
    assign store_write_ready = (state == pix_types_pkg::ST_WRITE);
    assign store_read_ready  = (state == pix_types_pkg::ST_READ);

    assign write_xfer = store_write_trigger && store_write_ready;
    assign read_xfer  = store_read_trigger && store_read_ready;
    assign last_word  = (word_cnt ==
        pix_geometry_pkg::WORD_ADDR_BITS'(pix_geometry_pkg::IMAGE_WORDS - 1));

    // Current word stays on the bus until the reader takes it
    assign store_read_data = mem[{blk, word_cnt}];

    always_ff @(posedge clk) begin
        if (write_xfer) begin
            mem[{blk, word_cnt}] <= store_write_data;
        end
    end

    // ==================================================================
    // Burst sequencing
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pix_types_pkg::ST_IDLE;
        end else begin
            case (state)
                pix_types_pkg::ST_IDLE: begin
                    if (store_cmd_trigger) begin
                        blk      <= store_cmd_block;
                        word_cnt <= '0;
                        state    <= store_cmd_write ? pix_types_pkg::ST_WRITE
                                                    : pix_types_pkg::ST_READ;
                    end
                end
                pix_types_pkg::ST_WRITE,
                pix_types_pkg::ST_READ: begin
                    if (write_xfer || read_xfer) begin
                        word_cnt <= word_cnt + 1'b1;
                        // Ready returns the cycle after the last word
                        if (last_word) state <= pix_types_pkg::ST_IDLE;
                    end
                end
                default:
                    state <= pix_types_pkg::ST_IDLE;
            endcase
        end
    end

    // Controller never leaves a write pending once a burst has ended
    a_no_idle_write: assert property (@(posedge clk) disable iff (rst)
        (state == pix_types_pkg::ST_IDLE) |-> !store_write_trigger);

endmodule

//--- src/pix_capture.sv
module pix_capture (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  capture_start,
    input  logic                                  pix_valid,
    input  logic [pix_geometry_pkg::PIX_BITS-1:0] pix_d,
    input  logic                                  pix_fv,
    input  logic                                  pix_lv,
    input  logic                                  fifo_pop,
    output logic                                  fifo_ready,
    output logic [pix_geometry_pkg::WORD_BITS-1:0] fifo_data
);

    // ==================================================================
    // Sensor pin registers
    // ==================================================================
    logic                                  pix_valid_q;
    logic [pix_geometry_pkg::PIX_BITS-1:0] pix_d_q;
    logic                                  pix_fv_q;
    logic                                  pix_lv_q;

    always_ff @(posedge clk) begin
        pix_d_q <= pix_d;
        if (rst) begin
            pix_valid_q <= 1'b0;
            pix_fv_q    <= 1'b0;
            pix_lv_q    <= 1'b0;
        end else begin
            pix_valid_q <= pix_valid;
            pix_fv_q    <= pix_fv;
            pix_lv_q    <= pix_lv;
        end
    end

    // ==================================================================
    // Frame synchronisation
    // ==================================================================
    pix_types_pkg::capture_state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pix_types_pkg::CAP_IDLE;
        end else begin
            case (state)
                pix_types_pkg::CAP_IDLE:
                    if (capture_start) state <= pix_types_pkg::CAP_WAIT_INVALID;
                // Skip any frame already in progress
                pix_types_pkg::CAP_WAIT_INVALID:
                    if (!pix_fv_q) state <= pix_types_pkg::CAP_WAIT_START;
                pix_types_pkg::CAP_WAIT_START:
                    if (pix_fv_q) state <= pix_types_pkg::CAP_STORE;
                pix_types_pkg::CAP_STORE:
                    if (!pix_fv_q) state <= pix_types_pkg::CAP_IDLE;
                default:
                    state <= pix_types_pkg::CAP_IDLE;
            endcase
        end
    end

    // Frame start cycle already counts, so a first pixel with fv is not lost
    logic storing;
    logic push;

    assign storing = pix_fv_q && (state == pix_types_pkg::CAP_WAIT_START ||
                                  state == pix_types_pkg::CAP_STORE);
    assign push    = storing && pix_valid_q && pix_lv_q;

    // ==================================================================
    // Pixel FIFO
    // ==================================================================
    logic [pix_geometry_pkg::WORD_BITS-1:0] fifo_mem [pix_geometry_pkg::FIFO_DEPTH];
    logic [$clog2(pix_geometry_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(pix_geometry_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(pix_geometry_pkg::FIFO_DEPTH):0]   fill;
    logic                                            pop;
    logic                                            full;

    assign pop        = fifo_pop && fifo_ready;
    assign full       = (fill == pix_geometry_pkg::FIFO_DEPTH);
    assign fifo_ready = (fill != '0);
    assign fifo_data  = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= {{(pix_geometry_pkg::WORD_BITS -
                                   pix_geometry_pkg::PIX_BITS){1'b0}}, pix_d_q};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Store drains one word per cycle, so the FIFO never fills up
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);

    // The controller pops only words that are there
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        fifo_pop |-> fifo_ready);

endmodule

//--- src/pix_controller.sv
module pix_controller (
    input  logic                                    clk,
    input  logic                                    rst,
    input  pix_types_pkg::cmd_op_e                  cmd,
    input  logic [pix_geometry_pkg::BLOCK_BITS-1:0] cmd_block,
    input  logic                                    cmd_trigger,
    output logic                                    cmd_done,
    output logic                                    capture_start,
    input  logic                                    fifo_ready,
    input  logic [pix_geometry_pkg::WORD_BITS-1:0]  fifo_data,
    output logic                                    fifo_pop,
    output logic                                    store_cmd_trigger,
    output logic [pix_geometry_pkg::BLOCK_BITS-1:0] store_cmd_block,
    output logic                                    store_cmd_write,
    input  logic                                    store_cmd_ready,
    output logic                                    store_write_trigger,
    output logic [pix_geometry_pkg::WORD_BITS-1:0]  store_write_data,
    input  logic                                    store_write_ready,
    input  logic                                    store_read_ready,
    input  logic [pix_geometry_pkg::WORD_BITS-1:0]  store_read_data,
    output logic                                    store_read_trigger,
    output logic                                    readout_ready,
    input  logic                                    readout_trigger,
    output logic [pix_geometry_pkg::WORD_BITS-1:0]  readout_data
);

    pix_types_pkg::ctrl_state_e state;
    logic                       cmd_trigger_q;
    logic                       cmd_ack;

    // Readout strobes go straight to the store
    assign readout_ready      = store_read_ready;
    assign readout_data       = store_read_data;
    assign store_read_trigger = readout_trigger;

    assign capture_start = (state == pix_types_pkg::CTRL_CAPTURE_START);

    // Take a word whenever the write slot is empty or being emptied
    assign fifo_pop = (state == pix_types_pkg::CTRL_CAPTURE_COPY) && fifo_ready &&
                      (!store_write_trigger || store_write_ready);

    // ==================================================================
    // Command sequencer
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state               <= pix_types_pkg::CTRL_IDLE;
            cmd_trigger_q       <= 1'b0;
            cmd_ack             <= 1'b0;
            cmd_done            <= 1'b0;
            store_cmd_trigger   <= 1'b0;
            store_write_trigger <= 1'b0;
        end else begin
            cmd_trigger_q <= cmd_trigger;
            case (state)
                pix_types_pkg::CTRL_IDLE: begin
                    if (cmd_trigger_q != cmd_ack) begin
                        cmd_ack         <= cmd_trigger_q;
                        store_cmd_block <= cmd_block;
                        if (cmd == pix_types_pkg::CMD_CAPTURE) begin
                            state <= pix_types_pkg::CTRL_CAPTURE_START;
                        end else begin
                            store_cmd_write   <= 1'b0;
                            store_cmd_trigger <= 1'b1;
                            state             <= pix_types_pkg::CTRL_READOUT_CMD;
                        end
                    end
                end
                // Capture block is armed this cycle
                pix_types_pkg::CTRL_CAPTURE_START: begin
                    store_cmd_write   <= 1'b1;
                    store_cmd_trigger <= 1'b1;
                    state             <= pix_types_pkg::CTRL_CAPTURE_CMD;
                end
                pix_types_pkg::CTRL_CAPTURE_CMD: begin
                    if (store_cmd_trigger && store_cmd_ready) begin
                        store_cmd_trigger <= 1'b0;
                        state             <= pix_types_pkg::CTRL_CAPTURE_COPY;
                    end
                end
                pix_types_pkg::CTRL_CAPTURE_COPY: begin
                    if (store_write_trigger && store_write_ready) begin
                        store_write_trigger <= 1'b0;
                    end
                    if (fifo_pop) begin
                        store_write_data    <= fifo_data;
                        store_write_trigger <= 1'b1;
                    end
                    // Store knows the frame size and ends the burst itself
                    if (store_cmd_ready) begin
                        cmd_done <= ~cmd_done;
                        state    <= pix_types_pkg::CTRL_IDLE;
                    end
                end
                pix_types_pkg::CTRL_READOUT_CMD: begin
                    if (store_cmd_trigger && store_cmd_ready) begin
                        store_cmd_trigger <= 1'b0;
                        state             <= pix_types_pkg::CTRL_READOUT_WAIT;
                    end
                end
                pix_types_pkg::CTRL_READOUT_WAIT: begin
                    if (store_cmd_ready) begin
                        cmd_done <= ~cmd_done;
                        state    <= pix_types_pkg::CTRL_IDLE;
                    end
                end
                default:
                    state <= pix_types_pkg::CTRL_IDLE;
            endcase
        end
    end

    // Outside waits for cmd_done before the next toggle
    a_no_toggle_busy: assert property (@(posedge clk) disable iff (rst)
        (state != pix_types_pkg::CTRL_IDLE) |-> (cmd_trigger_q == cmd_ack));

endmodule

//--- src/pix_geometry_pkg.sv
package pix_geometry_pkg;

    // ==================================================================
    // Sensor and word widths
    // ==================================================================
    localparam int PIX_BITS  = 12;
    localparam int WORD_BITS = 16;

    // ==================================================================
    // Frame geometry, one frame fills one block
    // ==================================================================
    localparam int IMAGE_WIDTH  = 8;
    localparam int IMAGE_HEIGHT = 4;
    localparam int IMAGE_WORDS  = IMAGE_WIDTH * IMAGE_HEIGHT;

    // Block memory layout
    localparam int BLOCK_COUNT    = 8;
    localparam int BLOCK_BITS     = 3;
    localparam int WORD_ADDR_BITS = 5;

    // Pixel FIFO between sensor and store
    localparam int FIFO_DEPTH = 8;

endpackage

//--- src/pix_subsystem.sv
module pix_subsystem (
    input  logic                                    clk,
    input  logic                                    rst,
    input  pix_types_pkg::cmd_op_e                  cmd,
    input  logic [pix_geometry_pkg::BLOCK_BITS-1:0] cmd_block,
    input  logic                                    cmd_trigger,
    output logic                                    cmd_done,
    input  logic                                    pix_valid,
    input  logic [pix_geometry_pkg::PIX_BITS-1:0]   pix_d,
    input  logic                                    pix_fv,
    input  logic                                    pix_lv,
    output logic                                    readout_ready,
    input  logic                                    readout_trigger,
    output logic [pix_geometry_pkg::WORD_BITS-1:0]  readout_data
);

    // ==================================================================
    // Internal links
    // ==================================================================
    logic                                    capture_start;
    logic                                    fifo_ready;
    logic [pix_geometry_pkg::WORD_BITS-1:0]  fifo_data;
    logic                                    fifo_pop;
    logic                                    store_cmd_trigger;
    logic [pix_geometry_pkg::BLOCK_BITS-1:0] store_cmd_block;
    logic                                    store_cmd_write;
    logic                                    store_cmd_ready;
    logic                                    store_write_trigger;
    logic [pix_geometry_pkg::WORD_BITS-1:0]  store_write_data;
    logic                                    store_write_ready;
    logic                                    store_read_trigger;
    logic                                    store_read_ready;
    logic [pix_geometry_pkg::WORD_BITS-1:0]  store_read_data;

    pix_capture pix_capture_inst (
        .clk           (clk),
        .rst           (rst),
        .capture_start (capture_start),
        .pix_valid     (pix_valid),
        .pix_d         (pix_d),
        .pix_fv        (pix_fv),
        .pix_lv        (pix_lv),
        .fifo_pop      (fifo_pop),
        .fifo_ready    (fifo_ready),
        .fifo_data     (fifo_data)
    );

    block_store block_store_inst (
        .clk                 (clk),
        .rst                 (rst),
        .store_cmd_trigger   (store_cmd_trigger),
        .store_cmd_block     (store_cmd_block),
        .store_cmd_write     (store_cmd_write),
        .store_cmd_ready     (store_cmd_ready),
        .store_write_trigger (store_write_trigger),
        .store_write_data    (store_write_data),
        .store_write_ready   (store_write_ready),
        .store_read_trigger  (store_read_trigger),
        .store_read_ready    (store_read_ready),
        .store_read_data     (store_read_data)
    );

    pix_controller pix_controller_inst (
        .clk                 (clk),
        .rst                 (rst),
        .cmd                 (cmd),
        .cmd_block           (cmd_block),
        .cmd_trigger         (cmd_trigger),
        .cmd_done            (cmd_done),
        .capture_start       (capture_start),
        .fifo_ready          (fifo_ready),
        .fifo_data           (fifo_data),
        .fifo_pop            (fifo_pop),
        .store_cmd_trigger   (store_cmd_trigger),
        .store_cmd_block     (store_cmd_block),
        .store_cmd_write     (store_cmd_write),
        .store_cmd_ready     (store_cmd_ready),
        .store_write_trigger (store_write_trigger),
        .store_write_data    (store_write_data),
        .store_write_ready   (store_write_ready),
        .store_read_ready    (store_read_ready),
        .store_read_data     (store_read_data),
        .store_read_trigger  (store_read_trigger),
        .readout_ready       (readout_ready),
        .readout_trigger     (readout_trigger),
        .readout_data        (readout_data)
    );

endmodule

//--- src/pix_types_pkg.sv
package pix_types_pkg;

    // Command opcode on the outside command port
    typedef enum logic {
        CMD_CAPTURE = 1'b0,
        CMD_READOUT = 1'b1
    } cmd_op_e;

    // Command sequencer
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_CAPTURE_START,
        CTRL_CAPTURE_CMD,
        CTRL_CAPTURE_COPY,
        CTRL_READOUT_CMD,
        CTRL_READOUT_WAIT
    } ctrl_state_e;

    // Frame synchronisation in the capture block
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_INVALID,
        CAP_WAIT_START,
        CAP_STORE
    } capture_state_e;

    // Block store burst state
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } store_state_e;

endpackage

//--- verif/pix_subsystem_tb.sv
module pix_subsystem_tb;

    localparam int NUM_ROWS        = 8;
    localparam int DONE_TIMEOUT    = 400;
    localparam int READOUT_TIMEOUT = 600;
    localparam int FRAME_TIMEOUT   = 200;

    // One command per row
    // Salt only matters for captures
    typedef struct packed {
        pix_types_pkg::cmd_op_e op;
        int                     blk;
        int                     salt;
        bit                     mid_frame;
        bit                     backpressure;
    } row_t;

    localparam row_t STIM_TABLE [NUM_ROWS] = '{
        '{pix_types_pkg::CMD_CAPTURE, 2, 7,   1'b0, 1'b0},
        '{pix_types_pkg::CMD_READOUT, 2, 0,   1'b0, 1'b0},
        '{pix_types_pkg::CMD_CAPTURE, 5, 300, 1'b0, 1'b0},
        '{pix_types_pkg::CMD_READOUT, 5, 0,   1'b0, 1'b0},
        '{pix_types_pkg::CMD_READOUT, 2, 0,   1'b0, 1'b0},
        '{pix_types_pkg::CMD_CAPTURE, 3, 40,  1'b1, 1'b0},
        '{pix_types_pkg::CMD_READOUT, 3, 0,   1'b0, 1'b1},
        '{pix_types_pkg::CMD_READOUT, 5, 0,   1'b0, 1'b1}
    };

    logic                                    clk;
    logic                                    rst;
    pix_types_pkg::cmd_op_e                  cmd;
    logic [pix_geometry_pkg::BLOCK_BITS-1:0] cmd_block;
    logic                                    cmd_trigger;
    logic                                    cmd_done;
    logic                                    pix_valid;
    logic [pix_geometry_pkg::PIX_BITS-1:0]   pix_d;
    logic                                    pix_fv;
    logic                                    pix_lv;
    logic                                    readout_ready;
    logic                                    readout_trigger;
    logic [pix_geometry_pkg::WORD_BITS-1:0]  readout_data;

    // Words each block should hold after its last capture
    logic [pix_geometry_pkg::WORD_BITS-1:0]
        expected_mem [pix_geometry_pkg::BLOCK_COUNT][pix_geometry_pkg::IMAGE_WORDS];

    integer seed;
    int     error_count;
    int     check_count;
    int     timeout_count;
    bit     aborted;

    pix_subsystem pix_subsystem_inst (
        .clk             (clk),
        .rst             (rst),
        .cmd             (cmd),
        .cmd_block       (cmd_block),
        .cmd_trigger     (cmd_trigger),
        .cmd_done        (cmd_done),
        .pix_valid       (pix_valid),
        .pix_d           (pix_d),
        .pix_fv          (pix_fv),
        .pix_lv          (pix_lv),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================================
    // Helpers
    // ==================================================================
    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (got !== expected) begin
            $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, expected);
            error_count++;
        end
    endtask

    function automatic logic rand_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic logic [pix_geometry_pkg::PIX_BITS-1:0] junk_value();
        int r;
        r = $random(seed);
        return r[pix_geometry_pkg::PIX_BITS-1:0];
    endfunction

    function automatic logic [pix_geometry_pkg::PIX_BITS-1:0] pixel_value(
        input int blk, input int idx, input int salt);
        return pix_geometry_pkg::PIX_BITS'(blk * 37 + idx * 5 + salt);
    endfunction

    task automatic drive_pins(input logic valid, input logic fv, input logic lv,
                              input logic [pix_geometry_pkg::PIX_BITS-1:0] d);
        @(posedge clk);
        pix_valid <= valid;
        pix_fv    <= fv;
        pix_lv    <= lv;
        pix_d     <= d;
    endtask

    // Sensor model for one full frame with blanking around the lines
    task automatic play_frame(input int blk, input int salt);
        int col;
        repeat (8) drive_pins(1'b0, 1'b0, 1'b0, junk_value());
        for (int line = 0; line < pix_geometry_pkg::IMAGE_HEIGHT; line++) begin
            col = 0;
            while (col < pix_geometry_pkg::IMAGE_WIDTH) begin
                if (rand_bit()) begin
                    drive_pins(1'b1, 1'b1, 1'b1,
                               pixel_value(blk, line * pix_geometry_pkg::IMAGE_WIDTH + col, salt));
                    col++;
                end else begin
                    drive_pins(1'b0, 1'b1, 1'b1, junk_value());
                end
            end
            // Junk strobes while line-valid is low
            repeat (3) drive_pins(1'b1, 1'b1, 1'b0, junk_value());
        end
        drive_pins(1'b0, 1'b0, 1'b0, junk_value());
    endtask

    task automatic issue_command(input pix_types_pkg::cmd_op_e op, input int blk);
        @(posedge clk);
        cmd       <= op;
        cmd_block <= pix_geometry_pkg::BLOCK_BITS'(blk);
        @(posedge clk);
        cmd_trigger <= ~cmd_trigger;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        timeout_count++;
        aborted = 1'b1;
    endtask

    task automatic wait_frame_valid();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!pix_fv && cycles < FRAME_TIMEOUT);
        if (!pix_fv) report_timeout("the sensor frame to start");
    endtask

    // Done must flip and then stay put
    task automatic wait_done(input logic done_before, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (cmd_done == done_before && cycles < DONE_TIMEOUT);
        if (cmd_done == done_before) begin
            report_timeout({"cmd_done after ", what});
        end else begin
            repeat (2) @(negedge clk);
            check_value(32'(cmd_done), 32'(!done_before), {what, " cmd_done level"});
        end
    endtask

    // ==================================================================
    // Command runs
    // ==================================================================
    task automatic run_capture(input int blk, input int salt, input bit mid_frame);
        logic done_before;
        int   stored_salt;
        @(negedge clk);
        done_before = cmd_done;
        if (mid_frame) begin
            // The partial frame is skipped and the next one is stored
            fork
                begin
                    play_frame(blk, salt);
                    play_frame(blk, salt + 1);
                end
                begin
                    wait_frame_valid();
                    repeat (4) @(posedge clk);
                    if (!aborted) issue_command(pix_types_pkg::CMD_CAPTURE, blk);
                end
            join
            stored_salt = salt + 1;
        end else begin
            issue_command(pix_types_pkg::CMD_CAPTURE, blk);
            play_frame(blk, salt);
            stored_salt = salt;
        end
        wait_done(done_before, "capture");
        for (int i = 0; i < pix_geometry_pkg::IMAGE_WORDS; i++) begin
            expected_mem[blk][i] = pix_geometry_pkg::WORD_BITS'(pixel_value(blk, i, stored_salt));
        end
    endtask

    task automatic run_readout(input int blk, input bit backpressure);
        logic done_before;
        int   count;
        int   cycles;
        @(negedge clk);
        done_before = cmd_done;
        issue_command(pix_types_pkg::CMD_READOUT, blk);
        count  = 0;
        cycles = 0;
        while (cmd_done == done_before && cycles < READOUT_TIMEOUT) begin
            @(posedge clk);
            readout_trigger <= backpressure ? rand_bit() : 1'b1;
            @(negedge clk);
            cycles++;
            // Word moves on the coming edge
            if (readout_ready && readout_trigger) begin
                if (count < pix_geometry_pkg::IMAGE_WORDS) begin
                    check_value(32'(readout_data), 32'(expected_mem[blk][count]),
                                "readout word");
                end
                count++;
            end
        end
        @(posedge clk);
        readout_trigger <= 1'b0;
        if (cmd_done == done_before) begin
            report_timeout("cmd_done after readout");
        end else begin
            check_value(count, pix_geometry_pkg::IMAGE_WORDS, "readout word count");
            repeat (2) @(negedge clk);
            check_value(32'(cmd_done), 32'(!done_before), "readout cmd_done level");
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        row_t row;
        seed            = 84033;
        error_count     = 0;
        check_count     = 0;
        timeout_count   = 0;
        aborted         = 1'b0;
        rst             = 1'b1;
        cmd             = pix_types_pkg::CMD_CAPTURE;
        cmd_block       = '0;
        cmd_trigger     = 1'b0;
        pix_valid       = 1'b0;
        pix_d           = '0;
        pix_fv          = 1'b0;
        pix_lv          = 1'b0;
        readout_trigger = 1'b0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value(32'(cmd_done), 0, "cmd_done after reset");
        check_value(32'(readout_ready), 0, "readout_ready after reset");

        for (int i = 0; i < NUM_ROWS && !aborted; i++) begin
            row = STIM_TABLE[i];
            if (row.op == pix_types_pkg::CMD_CAPTURE) begin
                run_capture(row.blk, row.salt, row.mid_frame);
            end else begin
                run_readout(row.blk, row.backpressure);
            end
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
